/* src/video_geom_pkg.sv */
package video_geom_pkg;

	// raster geometry of one sprite line
	localparam int LINE_PIX_DEF = 512;
	localparam int XADDR_W = 9;
	localparam int PIX_W = 8;

	// position within a line, covers 512
	typedef logic [XADDR_W-1:0] xaddr_t;

	// palette index for gfx, border and output
	typedef logic [PIX_W-1:0] pix_t;

	// step right with wrap at line end
	function automatic xaddr_t xaddr_inc(xaddr_t x, int line_pix);
		return (x == xaddr_t'(line_pix - 1)) ? '0 : x + 1'b1;
	endfunction

	// step left, wraps to the last column
	function automatic xaddr_t xaddr_dec(xaddr_t x, int line_pix);
		return (x == '0) ? xaddr_t'(line_pix - 1) : x - 1'b1;
	endfunction

endpackage

/* src/ts_fmt_pkg.sv */
package ts_fmt_pkg;

	// sprite pixels are nibbles, eight to a fetched word
	localparam int TS_NIB_W = 4;
	localparam int TS_WORD_PIX = 8;
	localparam int TS_WORD_W = TS_NIB_W * TS_WORD_PIX;

	// width code, sprite is (code+1)*8 pixels wide
	typedef logic [2:0] ts_xsize_t;

	// palette bank
	typedef logic [TS_NIB_W-1:0] ts_pal_t;

	// colour within the bank
	typedef logic [TS_NIB_W-1:0] ts_nib_t;

	// fetched word, pixel 0 in the top nibble
	typedef logic [TS_WORD_W-1:0] ts_word_t;

	// buffered pixel as {bank, colour}
	typedef logic [2*TS_NIB_W-1:0] ts_pix_t;

	function automatic ts_pix_t ts_pix_make(ts_pal_t pal, ts_nib_t nib);
		return {pal, nib};
	endfunction

	// colour 0 lets the layer below show through
	function automatic logic ts_pix_opaque(ts_pix_t p);
		return p[TS_NIB_W-1:0] != '0;
	endfunction

endpackage

/* src/ts_render.sv */
module ts_render #(
	parameter int LINE_PIX = video_geom_pkg::LINE_PIX_DEF
) (
	input  logic                   clk,
	input  logic                   arst_n,

	// sprite descriptor
	input  logic                   tsr_go,
	input  video_geom_pkg::xaddr_t tsr_x,
	input  ts_fmt_pkg::ts_xsize_t  tsr_xs,
	input  logic                   tsr_xf,
	input  ts_fmt_pkg::ts_pal_t    tsr_pal,

	// pixel memory
	output logic                   mem_req,
	input  logic                   mem_rdy,
	input  ts_fmt_pkg::ts_word_t   mem_data,

	output logic                   ts_busy,

	// line buffer write port
	output video_geom_pkg::xaddr_t wr_addr,
	output ts_fmt_pkg::ts_pix_t    wr_data,
	output logic                   wr_en
);
	import video_geom_pkg::*;
	import ts_fmt_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_WRITE
	} state_t;

	// one spare bit for the flipped start column
	localparam logic [XADDR_W:0] LINE_PIX_X = (XADDR_W+1)'(LINE_PIX);

	state_t state;
	ts_xsize_t words_left;
	logic [2:0] pix_cnt;

	ts_pal_t pal_q;
	logic flip_q;
	ts_word_t shreg;
	xaddr_t pos;

	logic [XADDR_W:0] flip_end;
	xaddr_t start_pos;
	logic accept;
	logic word_done;

	assign accept = tsr_go && !ts_busy;
	assign word_done = (state == ST_WRITE) && (&pix_cnt);

	// flipped sprites start at x + width - 1
	always_comb begin
		flip_end = {1'b0, tsr_x} + (XADDR_W+1)'({tsr_xs, 3'b111});
		if (flip_end >= LINE_PIX_X)
			flip_end = flip_end - LINE_PIX_X;
		start_pos = tsr_xf ? flip_end[XADDR_W-1:0] : tsr_x;
	end

	assign mem_req = (state == ST_FETCH);
	assign ts_busy = (state != ST_IDLE);

	// top nibble of the shift register is the pixel going out
	assign wr_addr = pos;
	assign wr_data = ts_pix_make(pal_q, shreg[TS_WORD_W-1 -: TS_NIB_W]);
	assign wr_en = (state == ST_WRITE) && ts_pix_opaque(wr_data);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			words_left <= '0;
			pix_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_FETCH;
						words_left <= tsr_xs;
					end
				end

				// hold the request until memory answers
				ST_FETCH: begin
					if (mem_rdy) begin
						state <= ST_WRITE;
						pix_cnt <= '0;
					end
				end

				ST_WRITE: begin
					pix_cnt <= pix_cnt + 1'b1;
					if (word_done) begin
						if (words_left == '0) begin
							state <= ST_IDLE;
						end else begin
							state <= ST_FETCH;
							words_left <= words_left - 1'b1;
						end
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// descriptor, fetched word and write position
	always_ff @(posedge clk) begin
		if (accept) begin
			pal_q <= tsr_pal;
			flip_q <= tsr_xf;
			pos <= start_pos;
		end

		if ((state == ST_FETCH) && mem_rdy) begin
			shreg <= mem_data;
		end else if (state == ST_WRITE) begin
			shreg <= shreg << TS_NIB_W;
			pos <= flip_q ? xaddr_dec(pos, LINE_PIX) : xaddr_inc(pos, LINE_PIX);
		end
	end

endmodule

/* src/ts_line_buf.sv */
module ts_line_buf #(
	parameter int LINE_PIX = video_geom_pkg::LINE_PIX_DEF
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   line_start,

	// renderer side
	input  video_geom_pkg::xaddr_t wr_addr,
	input  ts_fmt_pkg::ts_pix_t    wr_data,
	input  logic                   wr_en,

	// mixer side
	input  video_geom_pkg::xaddr_t rd_addr,
	input  logic                   rd_stb,
	output ts_fmt_pkg::ts_pix_t    rd_data
);
	import ts_fmt_pkg::*;

	localparam int AW = $clog2(LINE_PIX);

	// bank being filled, the other one is on display
	logic wr_bank;

	logic [AW-1:0] wa;
	logic [AW-1:0] ra;

	ts_pix_t mem0 [LINE_PIX];
	ts_pix_t mem1 [LINE_PIX];

	logic [AW-1:0] waddr0;
	logic [AW-1:0] waddr1;
	ts_pix_t wdata0;
	ts_pix_t wdata1;
	logic we0;
	logic we1;

	assign wa = wr_addr[AW-1:0];
	assign ra = rd_addr[AW-1:0];

	// displayed bank takes the read address and writes zero behind it
	assign waddr0 = wr_bank ? ra : wa;
	assign wdata0 = wr_bank ? '0 : wr_data;
	assign we0    = wr_bank ? rd_stb : wr_en;

	assign waddr1 = wr_bank ? wa : ra;
	assign wdata1 = wr_bank ? wr_data : '0;
	assign we1    = wr_bank ? wr_en : rd_stb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wr_bank <= 1'b0;
		else if (line_start)
			wr_bank <= ~wr_bank;
	end

	always_ff @(posedge clk) begin
		if (we0)
			mem0[waddr0] <= wdata0;
		if (we1)
			mem1[waddr1] <= wdata1;
	end

	// old contents come out while the location is cleared
	always_ff @(posedge clk) begin
		if (rd_stb)
			rd_data <= wr_bank ? mem0[ra] : mem1[ra];
	end

endmodule

/* src/ts_mixer.sv */
module ts_mixer #(
	parameter int LINE_PIX = video_geom_pkg::LINE_PIX_DEF
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   line_start,

	// pixel timing and graphics layer
	input  logic                   pix_stb,
	input  logic                   hvpix,
	input  video_geom_pkg::pix_t   gfx_pix,
	input  video_geom_pkg::pix_t   border,

	// line buffer read port
	output video_geom_pkg::xaddr_t rd_addr,
	output logic                   rd_stb,
	input  ts_fmt_pkg::ts_pix_t    rd_data,

	output video_geom_pkg::pix_t   vplex,
	output logic                   vplex_stb
);
	import video_geom_pkg::*;
	import ts_fmt_pkg::*;

	xaddr_t scan_x;
	logic stb_d;

	// graphics side, delayed to meet the buffer read
	logic hv_d;
	pix_t gfx_d;
	pix_t border_d;

	assign rd_addr = scan_x;
	assign rd_stb = pix_stb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_x <= '0;
			stb_d <= 1'b0;
			vplex_stb <= 1'b0;
		end else begin
			if (line_start)
				scan_x <= '0;
			else if (pix_stb)
				scan_x <= xaddr_inc(scan_x, LINE_PIX);

			stb_d <= pix_stb;
			vplex_stb <= stb_d;
		end
	end

	always_ff @(posedge clk) begin
		if (pix_stb) begin
			hv_d <= hvpix;
			gfx_d <= gfx_pix;
			border_d <= border;
		end
	end

	// border first, then an opaque sprite pixel, then graphics
	always_ff @(posedge clk) begin
		if (stb_d) begin
			if (!hv_d)
				vplex <= border_d;
			else if (ts_pix_opaque(rd_data))
				vplex <= pix_t'(rd_data);
			else
				vplex <= gfx_d;
		end
	end

endmodule

/* src/video_ts_line.sv */
module video_ts_line #(
	parameter int LINE_PIX = video_geom_pkg::LINE_PIX_DEF
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   line_start,

	// sprite descriptor
	input  logic                   tsr_go,
	input  video_geom_pkg::xaddr_t tsr_x,
	input  ts_fmt_pkg::ts_xsize_t  tsr_xs,
	input  logic                   tsr_xf,
	input  ts_fmt_pkg::ts_pal_t    tsr_pal,
	output logic                   ts_busy,

	// sprite pixel memory
	output logic                   mem_req,
	input  logic                   mem_rdy,
	input  ts_fmt_pkg::ts_word_t   mem_data,

	// display side
	input  logic                   pix_stb,
	input  logic                   hvpix,
	input  video_geom_pkg::pix_t   gfx_pix,
	input  video_geom_pkg::pix_t   border,
	output video_geom_pkg::pix_t   vplex,
	output logic                   vplex_stb
);
	import video_geom_pkg::*;
	import ts_fmt_pkg::*;

	// renderer to line buffer
	xaddr_t  ts_waddr;
	ts_pix_t ts_wdata;
	logic    ts_we;

	// mixer to line buffer
	xaddr_t  ts_raddr;
	logic    ts_rstb;
	ts_pix_t ts_rdata;

	ts_render #(
		.LINE_PIX   (LINE_PIX)
	) ts_render (
		.clk        (clk),
		.arst_n     (arst_n),
		.tsr_go     (tsr_go),
		.tsr_x      (tsr_x),
		.tsr_xs     (tsr_xs),
		.tsr_xf     (tsr_xf),
		.tsr_pal    (tsr_pal),
		.mem_req    (mem_req),
		.mem_rdy    (mem_rdy),
		.mem_data   (mem_data),
		.ts_busy    (ts_busy),
		.wr_addr    (ts_waddr),
		.wr_data    (ts_wdata),
		.wr_en      (ts_we)
	);

	ts_line_buf #(
		.LINE_PIX   (LINE_PIX)
	) ts_line_buf (
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.wr_addr    (ts_waddr),
		.wr_data    (ts_wdata),
		.wr_en      (ts_we),
		.rd_addr    (ts_raddr),
		.rd_stb     (ts_rstb),
		.rd_data    (ts_rdata)
	);

	ts_mixer #(
		.LINE_PIX   (LINE_PIX)
	) ts_mixer (
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.pix_stb    (pix_stb),
		.hvpix      (hvpix),
		.gfx_pix    (gfx_pix),
		.border     (border),
		.rd_addr    (ts_raddr),
		.rd_stb     (ts_rstb),
		.rd_data    (ts_rdata),
		.vplex      (vplex),
		.vplex_stb  (vplex_stb)
	);

endmodule

/* tests/tb_video_ts_line.sv */
module tb_video_ts_line;
	timeunit 1ns;
	timeprecision 100ps;

	import video_geom_pkg::*;
	import ts_fmt_pkg::*;

	localparam int LINE_PIX = 512;
	localparam int CLK_PERIOD = 4;
	localparam int N_TESTS = 5;
	localparam pix_t BORDER_COL = 8'he3;

	logic clk = 1'b0;
	logic arst_n = 1'b1;
	logic line_start = 1'b0;
	logic tsr_go = 1'b0;
	xaddr_t tsr_x = '0;
	ts_xsize_t tsr_xs = '0;
	logic tsr_xf = 1'b0;
	ts_pal_t tsr_pal = '0;
	logic mem_rdy = 1'b0;
	ts_word_t mem_data = '0;
	logic pix_stb = 1'b0;
	logic hvpix = 1'b0;
	pix_t gfx_pix = '0;
	pix_t border = BORDER_COL;

	logic mem_req;
	logic ts_busy;
	pix_t vplex;
	logic vplex_stb;

	integer seed = 32'ha792a55c;
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int line_no = 0;
	int cyc = 0;

	// words served by the memory model in fetch order
	ts_word_t sprite_words [8];

	// expected line being written and line on display
	ts_pix_t line_next [LINE_PIX];
	ts_pix_t line_shown [LINE_PIX];

	// expected vplex values in flight and the cycle each one is due
	pix_t exp_q [$];
	int pos_q [$];
	int due_q [$];

	video_ts_line #(
		.LINE_PIX   (LINE_PIX)
	) video_ts_line_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.line_start (line_start),
		.tsr_go     (tsr_go),
		.tsr_x      (tsr_x),
		.tsr_xs     (tsr_xs),
		.tsr_xf     (tsr_xf),
		.tsr_pal    (tsr_pal),
		.ts_busy    (ts_busy),
		.mem_req    (mem_req),
		.mem_rdy    (mem_rdy),
		.mem_data   (mem_data),
		.pix_stb    (pix_stb),
		.hvpix      (hvpix),
		.gfx_pix    (gfx_pix),
		.border     (border),
		.vplex      (vplex),
		.vplex_stb  (vplex_stb)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_pix(input string name, input pix_t got, input pix_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %02h expected %02h at %0t ns", name, got, exp, $time);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %0h expected %0h at %0t ns", name, got, exp, $time);
			err_cnt++;
		end
	endtask

	// step to the falling edge and compare any mixer output due now
	task automatic next_cycle();
		int due;
		int pos;
		@(negedge clk);
		cyc++;
		if (vplex_stb) begin
			if (exp_q.size() == 0) begin
				$display("vplex_stb pulsed at %0t ns with no pixel in flight", $time);
				err_cnt++;
			end else begin
				due = due_q.pop_front();
				pos = pos_q.pop_front();
				if (cyc != due) begin
					$display("vplex_stb for pixel %0d came %0d cycles after pix_stb instead of 2",
						pos, cyc - due + 2);
					err_cnt++;
				end
				check_pix($sformatf("vplex[%0d]", pos), vplex, exp_q.pop_front());
			end
		end
	endtask

	task automatic start_line();
		int i;
		ts_pix_t tmp;
		next_cycle();
		line_start = 1'b1;
		next_cycle();
		line_start = 1'b0;
		// banks trade places
		for (i = 0; i < LINE_PIX; i++) begin
			tmp = line_shown[i];
			line_shown[i] = line_next[i];
			line_next[i] = tmp;
		end
		line_no++;
	endtask

	// hvpix is low on the first and last edge_w positions
	task automatic scan_line(input int gap, input int edge_w);
		int pos;
		int g;
		int n;
		logic hv;
		pix_t gfx;
		for (pos = 0; pos < LINE_PIX; pos++) begin
			hv = (pos >= edge_w) && (pos < LINE_PIX - edge_w);
			gfx = pix_t'(pos * 3 + line_no * 17);
			next_cycle();
			pix_stb = 1'b1;
			hvpix = hv;
			gfx_pix = gfx;
			// border, then opaque sprite pixel, then graphics
			if (!hv)
				exp_q.push_back(BORDER_COL);
			else if (line_shown[pos][3:0] != 4'h0)
				exp_q.push_back(pix_t'(line_shown[pos]));
			else
				exp_q.push_back(gfx);
			pos_q.push_back(pos);
			due_q.push_back(cyc + 2);
			line_shown[pos] = '0;
			for (g = 0; g < gap; g++) begin
				next_cycle();
				pix_stb = 1'b0;
			end
		end
		next_cycle();
		pix_stb = 1'b0;
		hvpix = 1'b0;
		n = 0;
		while (exp_q.size() != 0 && n < 8) begin
			next_cycle();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("vplex_stb missing for %0d pixels of line %0d", exp_q.size(), line_no);
			err_cnt += exp_q.size();
			exp_q.delete();
			pos_q.delete();
			due_q.delete();
		end
	endtask

	// sprite_words must hold the sprite before the call
	task automatic draw_sprite(input xaddr_t x, input ts_xsize_t xs, input logic xf,
			input ts_pal_t pal, input bit poke);
		int width;
		int k;
		int p;
		int n;
		int wait_cnt;
		int widx;
		logic [3:0] nib;
		width = (int'(xs) + 1) * 8;
		for (k = 0; k < width; k++) begin
			nib = sprite_words[k / 8][31 - 4 * (k % 8) -: 4];
			p = xf ? (int'(x) + width - 1 - k) % LINE_PIX : (int'(x) + k) % LINE_PIX;
			if (nib != 4'h0)
				line_next[p] = {pal, nib};
		end
		next_cycle();
		tsr_go = 1'b1;
		tsr_x = x;
		tsr_xs = xs;
		tsr_xf = xf;
		tsr_pal = pal;
		next_cycle();
		tsr_go = 1'b0;
		check_bit("ts_busy", ts_busy, 1'b1);
		n = 0;
		wait_cnt = -1;
		widx = 0;
		while (ts_busy && n < 200) begin
			// memory answers after 0 to 3 cycles
			if (mem_rdy) begin
				mem_rdy = 1'b0;
				check_bit("mem_req", mem_req, 1'b0);
			end else if (mem_req) begin
				if (wait_cnt < 0)
					wait_cnt = $random(seed) & 3;
				if (wait_cnt == 0) begin
					mem_rdy = 1'b1;
					mem_data = sprite_words[widx & 7];
					widx++;
					wait_cnt = -1;
				end else begin
					wait_cnt--;
				end
			end
			// a second descriptor while busy has to be dropped
			tsr_go = poke && (n == 2);
			if (tsr_go) begin
				tsr_x = 9'd0;
				tsr_pal = 4'hf;
				tsr_xf = ~xf;
			end
			next_cycle();
			n++;
		end
		mem_rdy = 1'b0;
		tsr_go = 1'b0;
		if (ts_busy) begin
			$display("ts_busy still high 200 cycles after sprite start at x %0d", x);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	task automatic test_reset();
		int e0;
		int i;
		e0 = err_cnt;
		next_cycle();
		arst_n = 1'b0;
		for (i = 0; i < 3; i++) begin
			next_cycle();
			check_bit("mem_req", mem_req, 1'b0);
			check_bit("ts_busy", ts_busy, 1'b0);
			check_bit("vplex_stb", vplex_stb, 1'b0);
		end
		arst_n = 1'b1;
		next_cycle();
		check_bit("mem_req", mem_req, 1'b0);
		check_bit("ts_busy", ts_busy, 1'b0);
		check_bit("vplex_stb", vplex_stb, 1'b0);
		// border hides the junk in both banks until their first read
		start_line();
		scan_line(0, LINE_PIX / 2);
		start_line();
		scan_line(0, LINE_PIX / 2);
		start_line();
		scan_line(0, 0);
		finish_test("reset state", e0);
	endtask

	task automatic test_single();
		int e0;
		e0 = err_cnt;
		sprite_words[0] = 32'h1203_4560;
		sprite_words[1] = 32'h0abc_de0f;
		draw_sprite(9'd40, 3'd1, 1'b0, 4'h5, 1'b0);
		start_line();
		scan_line(1, 0);
		finish_test("single sprite", e0);
	endtask

	task automatic test_flip();
		int e0;
		int i;
		e0 = err_cnt;
		for (i = 0; i < 8; i++)
			sprite_words[i] = ts_word_t'(32'h1234_5678 + i * 32'h1111_1111);
		sprite_words[3] = 32'h0f0e_0d0c;
		draw_sprite(9'd200, 3'd7, 1'b1, 4'h9, 1'b0);
		start_line();
		scan_line(0, 0);
		finish_test("flip and width", e0);
	endtask

	task automatic test_overlap();
		int e0;
		e0 = err_cnt;
		sprite_words[0] = 32'hffff_ffff;
		sprite_words[1] = 32'heeee_eeee;
		draw_sprite(9'd20, 3'd1, 1'b0, 4'h2, 1'b0);
		// later sprite on top with holes that let the first one through
		sprite_words[0] = 32'h1010_1010;
		sprite_words[1] = 32'h2222_0000;
		draw_sprite(9'd28, 3'd1, 1'b0, 4'h7, 1'b0);
		// half hidden by the right border
		sprite_words[0] = 32'h3333_3333;
		draw_sprite(9'd476, 3'd0, 1'b0, 4'ha, 1'b0);
		start_line();
		scan_line(0, 32);
		finish_test("overlap and border", e0);
	endtask

	task automatic test_wrap();
		int e0;
		int i;
		e0 = err_cnt;
		for (i = 0; i < 3; i++)
			sprite_words[i] = $random(seed);
		draw_sprite(9'd500, 3'd2, 1'b0, 4'hc, 1'b1);
		start_line();
		scan_line(0, 0);
		// no new sprites so only graphics remain
		start_line();
		scan_line(0, 0);
		finish_test("read-clear and wraparound", e0);
	endtask

	initial begin
		#(N_TESTS * (2 * LINE_PIX + 300) * CLK_PERIOD);
		$display("watchdog expired at %0t ns before the tests finished", $time);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int i;
		for (i = 0; i < LINE_PIX; i++) begin
			line_next[i] = '0;
			line_shown[i] = '0;
		end
		test_reset();
		test_single();
		test_flip();
		test_overlap();
		test_wrap();
		$display("%0d tests ok, %0d tests failing, %0d errors", pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb.f */
src/video_geom_pkg.sv
src/ts_fmt_pkg.sv
src/ts_render.sv
src/ts_line_buf.sv
src/ts_mixer.sv
src/video_ts_line.sv
tests/tb_video_ts_line.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_video_ts_line
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
